// ==== verilog/lsu_defines.svh ====
/*
  Shared widths and opcodes for the load/store unit
    XLEN and PA_BITS data and physical address widths
    AMO_* funct5 codes of the RISC-V A extension
*/

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data word and physical address widths
`define XLEN    32
`define PA_BITS 32

// Atomic memory operation codes, as found in instr[31:27]
`define AMO_ADD  5'b00000
`define AMO_SWAP 5'b00001
`define AMO_XOR  5'b00100
`define AMO_OR   5'b01000
`define AMO_AND  5'b01100
`define AMO_MIN  5'b10000
`define AMO_MAX  5'b10100
`define AMO_MINU 5'b11000
`define AMO_MAXU 5'b11100

`endif

// ==== verilog/lsu_pkg.sv ====
/*
  Types shared by the load/store unit
    wordT, paddrT, memRwT, funct3T, amoOpT vector types
    cpuCtrlT memory-stage control word
    busReqT request fields driven onto the word bus
    busStateT bus sequencer states
*/

`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

  typedef logic [`XLEN-1:0]    wordT;
  typedef logic [`PA_BITS-1:0] paddrT;

  // Access kind: 10 read, 01 write, 11 AMO, 00 none
  typedef logic [1:0] memRwT;

  // Bits 1:0 are the size, bit 2 asks for zero extension
  typedef logic [2:0] funct3T;
  typedef logic [4:0] amoOpT;

  // Control word of the instruction sitting in the memory stage
  typedef struct packed {
    memRwT      memRw;
    funct3T     funct3;
    amoOpT      amoOp;
    logic [1:0] atomic;   // 01 AMO, 10 LR/SC
  } cpuCtrlT;

  // Everything the unit drives toward the bus slave
  typedef struct packed {
    paddrT      adr;
    logic       read;
    logic       write;
    logic [1:0] size;
    wordT       wdata;
  } busReqT;

  typedef enum logic [1:0] {IDLE, READ, WRITE, DONE} busStateT;

endpackage

`default_nettype wire

// ==== verilog/subwordDp.sv ====
/*
  Subword datapath
    load side picks the byte or halfword lane and extends it
    store side replicates the low byte or halfword into all lanes
*/

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module subwordDp import lsu_pkg::*; (
  input  logic [1:0] adrLow,
  input  funct3T     funct3,
  input  wordT       rawWord,
  input  wordT       storeData,
  output wordT       loadData,
  output wordT       laneData
);

  logic [7:0]  byteLane;
  logic [15:0] halfLane;

  // Byte lane chosen by the two low address bits
  always_comb begin
    case (adrLow)
      2'b00:   byteLane = rawWord[7:0];
      2'b01:   byteLane = rawWord[15:8];
      2'b10:   byteLane = rawWord[23:16];
      default: byteLane = rawWord[31:24];
    endcase
  end

  // Halfword lane only depends on bit 1 since bit 0 is known clear
  assign halfLane = adrLow[1] ? rawWord[31:16] : rawWord[15:0];

  // Funct3 bit 2 turns the sign extension into zero extension
  always_comb begin
    case (funct3)
      3'b000:  loadData = {{(`XLEN-8){byteLane[7]}}, byteLane};
      3'b001:  loadData = {{(`XLEN-16){halfLane[15]}}, halfLane};
      3'b100:  loadData = {{(`XLEN-8){1'b0}}, byteLane};
      3'b101:  loadData = {{(`XLEN-16){1'b0}}, halfLane};
      default: loadData = rawWord;
    endcase
  end

  // Copies go to every lane; the slave keeps the ones named by size and address
  always_comb begin
    case (funct3[1:0])
      2'b00:   laneData = {(`XLEN/8){storeData[7:0]}};
      2'b01:   laneData = {(`XLEN/16){storeData[15:0]}};
      default: laneData = storeData;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/amoUnit.sv ====
/*
  Atomic support for the load/store unit
    single LR reservation and SC squash decision
    access kind handed on to the bus sequencer
    AMO arithmetic on the old memory word and the register operand
*/

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module amoUnit import lsu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  cpuCtrlT ctrlM,
  input  paddrT   adrM,
  input  wordT    oldWord,
  input  wordT    operand,
  input  logic    readAck,
  input  logic    done,
  output memRwT   lsuRw,
  output logic    squashSc,
  output wordT    amoResult
);

  logic [`PA_BITS-1:2] resAdr;
  logic                resValid;
  logic                isLr;
  logic                isSc;
  logic                resHit;
  logic                lessSigned;
  logic                lessUnsigned;

  // LR is the read and SC the write of the LR/SC atomic class
  assign isLr = (ctrlM.atomic == 2'b10) & (ctrlM.memRw == 2'b10);
  assign isSc = (ctrlM.atomic == 2'b10) & (ctrlM.memRw == 2'b01);

  // Reservations are kept at word granularity
  assign resHit = resValid & (resAdr == adrM[`PA_BITS-1:2]);

  // A failing SC is turned into a no-op so it never reaches the bus
  assign squashSc = isSc & ~resHit;
  assign lsuRw    = squashSc ? 2'b00 : ctrlM.memRw;

  // The reservation is taken when the LR data comes back
  // Any SC gives it up, whether it wrote or was squashed
  always_ff @(posedge clk) begin
    if (rst) begin
      resValid <= 1'b0;
    end else if (isLr & readAck) begin
      resValid <= 1'b1;
    end else if (isSc & (done | squashSc)) begin
      resValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (isLr & readAck) begin
      resAdr <= adrM[`PA_BITS-1:2];
    end
  end

  ////////////////////////////////////////
  // AMO arithmetic
  ////////////////////////////////////////

  // Both comparisons ask whether the memory word is the smaller one
  assign lessSigned   = $signed(oldWord) < $signed(operand);
  assign lessUnsigned = oldWord < operand;

  always_comb begin
    case (ctrlM.amoOp)
      `AMO_SWAP: amoResult = operand;
      `AMO_ADD:  amoResult = oldWord + operand;
      `AMO_XOR:  amoResult = oldWord ^ operand;
      `AMO_AND:  amoResult = oldWord & operand;
      `AMO_OR:   amoResult = oldWord | operand;
      `AMO_MIN:  amoResult = lessSigned ? oldWord : operand;
      `AMO_MAX:  amoResult = lessSigned ? operand : oldWord;
      `AMO_MINU: amoResult = lessUnsigned ? oldWord : operand;
      `AMO_MAXU: amoResult = lessUnsigned ? operand : oldWord;
      // Unknown codes store the operand unchanged, like a swap
      default:   amoResult = operand;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/busFsm.sv ====
/*
  Bus sequencer for the load/store unit
    read, write and AMO read-then-write phases
    capture of the read word
    pipeline stall, committed level, read ack and done strobes
*/

`timescale 1ns/1ps
`default_nettype none

module busFsm import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       stallM,
  input  memRwT      lsuRw,
  input  logic       ignore,
  input  paddrT      adrM,
  input  logic [1:0] size,
  input  wordT       wdataRead,
  input  wordT       wdataAmo,
  input  logic       busAck,
  input  wordT       busRdata,
  output busReqT     busReq,
  output wordT       captured,
  output logic       busStall,
  output logic       committed,
  output logic       readAck,
  output logic       done
);

  busStateT state;
  busStateT nextState;
  logic     live;
  logic     isAmo;
  logic     readPhase;
  logic     writePhase;

  assign live  = (lsuRw != 2'b00) & ~ignore;
  assign isAmo = (lsuRw == 2'b11);

  // The request goes out straight from IDLE, so a slave can ack in the first cycle
  assign readPhase  = (state == READ) | ((state == IDLE) & live & lsuRw[1]);
  assign writePhase = (state == WRITE) | ((state == IDLE) & live & (lsuRw == 2'b01));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE, READ: begin
        if (readPhase) begin
          // An AMO turns its read into a write of the combined result
          if (busAck) nextState = isAmo ? WRITE : DONE;
          else nextState = READ;
        end else if (writePhase) begin
          nextState = busAck ? DONE : WRITE;
        end
      end
      WRITE: if (busAck) nextState = DONE;
      // Waiting here while the CPU stalls keeps the access from being issued twice
      DONE:  if (!stallM) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // The read word is kept for the load result and as the AMO old value
  always_ff @(posedge clk) begin
    if (readAck) begin
      captured <= busRdata;
    end
  end

  assign readAck = readPhase & busAck;
  // Last ack of the access: a plain read, or the write of a store or an AMO
  assign done    = (readAck & ~isAmo) | (writePhase & busAck);

  // Stall falls in DONE, the cycle after the final ack
  assign busStall  = readPhase | writePhase;
  assign committed = (state != IDLE);

  // The CPU is stalled for the whole access, so adrM and size hold still
  assign busReq.adr   = adrM;
  assign busReq.read  = readPhase;
  assign busReq.write = writePhase;
  assign busReq.size  = size;
  assign busReq.wdata = isAmo ? wdataAmo : wdataRead;

endmodule

`default_nettype wire

// ==== verilog/lsu.sv ====
/*
  Memory-stage load/store unit top level
    adrM pipeline register
    misalignment faults and request ignore
    stall and commit outputs toward the hazard and trap logic
    subword datapath, atomic unit and bus sequencer instances
*/

`timescale 1ns/1ps
`default_nettype none

module lsu import lsu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    stallM,
  input  logic    flushM,
  input  logic    trapM,
  input  paddrT   adrE,
  input  cpuCtrlT ctrlM,
  input  wordT    writeDataM,
  output logic    lsuStall,
  output wordT    readDataM,
  output logic    committedM,
  output logic    squashSc,
  output logic    loadMisalignedFault,
  output logic    storeMisalignedFault,
  output busReqT  busReq,
  input  logic    busAck,
  input  wordT    busRdata
);

  paddrT adrM;
  memRwT lsuRw;
  wordT  captured;
  wordT  amoResult;
  wordT  laneData;
  logic  accessM;
  logic  misaligned;
  logic  ignore;
  logic  busStall;
  logic  committed;
  logic  readAck;
  logic  done;
  logic  scFail;

  ////////////////////////////////////////
  // Address register and faults
  ////////////////////////////////////////

  // The address follows the instruction from execute into memory
  always_ff @(posedge clk) begin
    if (rst) begin
      adrM <= '0;
    end else if (flushM) begin
      adrM <= '0;
    end else if (!stallM) begin
      adrM <= adrE;
    end
  end

  // Halfwords need an even address, words a multiple of four
  always_comb begin
    case (ctrlM.funct3[1:0])
      2'b01:   misaligned = adrM[0];
      2'b10:   misaligned = |adrM[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  // Faults are checked on the raw access kind, before any SC squash
  assign accessM              = |ctrlM.memRw;
  assign loadMisalignedFault  = accessM & misaligned & (ctrlM.memRw == 2'b10);
  assign storeMisalignedFault = accessM & misaligned & (ctrlM.memRw != 2'b10);

  // A faulting or trapped instruction never reaches the bus
  assign ignore = misaligned | trapM;

  // Only the bus sequencer can hold the pipeline in this unit
  assign lsuStall   = busStall;
  // Once a bus phase has started, an interrupt must wait for the access to finish
  assign committedM = committed;

  // A successful SC has already given up its reservation by the time it sits in DONE
  assign squashSc = scFail & ~committed;

  ////////////////////////////////////////
  // Datapath blocks
  ////////////////////////////////////////

  // Load extraction works on the captured bus word; store lanes come from writeDataM
  subwordDp subwordDp (
    .adrLow   (adrM[1:0]),
    .funct3   (ctrlM.funct3),
    .rawWord  (captured),
    .storeData(writeDataM),
    .loadData (readDataM),
    .laneData (laneData)
  );

  amoUnit amoUnit (
    .clk, .rst, .ctrlM, .adrM,
    .oldWord  (captured),
    .operand  (writeDataM),
    .squashSc (scFail),
    .readAck, .done, .lsuRw, .amoResult
  );

  // AMOs are always word sized, so amoResult already fills every lane
  busFsm busFsm (
    .clk, .rst, .stallM, .lsuRw, .ignore, .adrM,
    .size     (ctrlM.funct3[1:0]),
    .wdataRead(laneData),
    .wdataAmo (amoResult),
    .busAck, .busRdata, .busReq, .captured,
    .busStall, .committed, .readAck, .done
  );

endmodule

`default_nettype wire

// ==== dv/lsu_props.sv ====
/*
  Bus and stall assertions for the load/store unit
    exclusive read and write levels, request stable until ack
    idle outputs after reset, no bus activity on faults or traps
*/

`timescale 1ns/1ps
`default_nettype none

module lsu_props import lsu_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    trapM,
  input cpuCtrlT ctrlM,
  input busReqT  busReq,
  input logic    busAck,
  input logic    lsuStall,
  input logic    committedM,
  input logic    loadMisalignedFault,
  input logic    storeMisalignedFault
);

  // Read by the testbench on every falling edge
  int failCount = 0;

  exclusiveRw: assert property (@(posedge clk) disable iff (rst)
    !(busReq.read && busReq.write))
    else begin
      $error("Bus read and write are high together");
      failCount = failCount + 1;
    end

  // A pending request keeps every field until the slave acks it
  stableUntilAck: assert property (@(posedge clk) disable iff (rst)
    (busReq.read || busReq.write) && !busAck |=> $stable(busReq))
    else begin
      $error("Bus request changed before its ack");
      failCount = failCount + 1;
    end

  idleAfterReset: assert property (@(posedge clk)
    rst |=> (ctrlM.memRw != 2'b00) || (!lsuStall && !committedM))
    else begin
      $error("Stall or committed high after reset with no request");
      failCount = failCount + 1;
    end

  // Once the FSM has left IDLE the access is committed and may finish
  noBusOnIgnore: assert property (@(posedge clk) disable iff (rst)
    (loadMisalignedFault || storeMisalignedFault || trapM) && !committedM
      |-> !(busReq.read || busReq.write))
    else begin
      $error("Faulting or trapped request reached the bus");
      failCount = failCount + 1;
    end

endmodule

bind lsu lsu_props u_props (.*);

`default_nettype wire

// ==== dv/lsu_tb.sv ====
/*
  Directed testbench for the load/store unit
    clock, reset and CPU-side stimulus on the falling edge
    byte-array bus memory with a random acknowledge delay
    compare tasks for data words, flags and memory contents
    load, store, misalignment, LR/SC, AMO and stall-hold tests
*/

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_tb import lsu_pkg::*; ();

  logic    clk;
  logic    rst;
  logic    stallM;
  logic    flushM;
  logic    trapM;
  paddrT   adrE;
  cpuCtrlT ctrlM;
  wordT    writeDataM;
  logic    lsuStall;
  wordT    readDataM;
  logic    committedM;
  logic    squashSc;
  logic    loadMisalignedFault;
  logic    storeMisalignedFault;
  busReqT  busReq;
  logic    busAck;
  wordT    busRdata;

  // Memory model state, 256 bytes decoded from the low address bits
  logic [7:0] mem [0:255];
  logic [7:0] memIdx;
  logic [2:0] ackDelay;
  logic [2:0] waitCnt;
  int         ackCount;

  // What the CPU saw during the last access
  string testName;
  wordT  lastRead;
  logic  snapSquash;
  logic  snapEndSquash;
  logic  snapLoadFault;
  logic  snapStoreFault;
  logic  snapStall;
  logic  snapReq;

  lsu u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////

  // Ack rises after ackDelay wait cycles; zero acks in the first request cycle
  assign memIdx   = {busReq.adr[7:2], 2'b00};
  assign busAck   = (busReq.read | busReq.write) & (waitCnt == ackDelay);
  assign busRdata = {mem[memIdx + 8'd3], mem[memIdx + 8'd2], mem[memIdx + 8'd1], mem[memIdx]};

  always @(posedge clk) begin
    if (rst) begin
      // Every address gets its own fill value
      for (int i = 0; i < 256; i++) begin
        mem[i] <= 8'(i) ^ 8'h5A;
      end
      waitCnt  <= '0;
      ackCount <= 0;
    end else if (busAck) begin
      // The slave keeps only the lanes named by size and address
      if (busReq.write) begin
        case (busReq.size)
          2'b00: mem[busReq.adr[7:0]] <= busReq.wdata[8 * busReq.adr[1:0] +: 8];
          2'b01: begin
            mem[{busReq.adr[7:1], 1'b0}] <= busReq.wdata[16 * busReq.adr[1] +: 8];
            mem[{busReq.adr[7:1], 1'b1}] <= busReq.wdata[16 * busReq.adr[1] + 8 +: 8];
          end
          default: begin
            mem[memIdx]        <= busReq.wdata[7:0];
            mem[memIdx + 8'd1] <= busReq.wdata[15:8];
            mem[memIdx + 8'd2] <= busReq.wdata[23:16];
            mem[memIdx + 8'd3] <= busReq.wdata[31:24];
          end
        endcase
      end
      waitCnt  <= '0;
      ackCount <= ackCount + 1;
    end else if (busReq.read | busReq.write) begin
      waitCnt <= waitCnt + 3'd1;
    end
  end

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkWord(input string what, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      reportFail($sformatf("CHECK FAILED %s: %s expected %h actual %h",
                           testName, what, expected, actual));
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      reportFail($sformatf("CHECK FAILED %s: %s expected %b actual %b",
                           testName, what, expected, actual));
    end
  endtask

  // Memory is read straight out of the model, not through the DUT
  task automatic checkRw(input string what, input paddrT adr, input wordT expected);
    logic [7:0] base;
    wordT       actual;
    base   = {adr[7:2], 2'b00};
    actual = {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
    if (actual !== expected) begin
      reportFail($sformatf("CHECK FAILED %s: %s at %h expected %h actual %h",
                           testName, what, adr, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  function automatic cpuCtrlT makeCtrl(input memRwT rw, input funct3T f3, input amoOpT op,
                                       input logic [1:0] atomic);
    cpuCtrlT ctrl;
    ctrl.memRw  = rw;
    ctrl.funct3 = f3;
    ctrl.amoOp  = op;
    ctrl.atomic = atomic;
    return ctrl;
  endfunction

  // Shift the addressed lane down, then extend from its top bit unless unsigned
  function automatic wordT expectLoad(input wordT word, input logic [1:0] off,
                                      input funct3T f3);
    wordT shifted;
    logic fill;
    shifted = word >> (8 * off);
    case (f3[1:0])
      2'b00: begin
        fill = f3[2] ? 1'b0 : shifted[7];
        return {{24{fill}}, shifted[7:0]};
      end
      2'b01: begin
        fill = f3[2] ? 1'b0 : shifted[15];
        return {{16{fill}}, shifted[15:0]};
      end
      default: return word;
    endcase
  endfunction

  function automatic wordT expectAmo(input amoOpT op, input wordT memVal, input wordT regVal);
    case (op)
      `AMO_SWAP: return regVal;
      `AMO_ADD:  return memVal + regVal;
      `AMO_XOR:  return memVal ^ regVal;
      `AMO_AND:  return memVal & regVal;
      `AMO_OR:   return memVal | regVal;
      `AMO_MIN:  return ($signed(regVal) < $signed(memVal)) ? regVal : memVal;
      `AMO_MAX:  return ($signed(regVal) > $signed(memVal)) ? regVal : memVal;
      `AMO_MINU: return (regVal < memVal) ? regVal : memVal;
      `AMO_MAXU: return (regVal > memVal) ? regVal : memVal;
      default:   return 'x;
    endcase
  endfunction

  ////////////////////////////////////////
  // Access sequencing
  ////////////////////////////////////////

  // Address enters in execute, the control word follows one cycle later in memory
  task automatic runAccess(input cpuCtrlT ctrl, input paddrT adr, input wordT wdata,
                           input int holdCycles);
    int cycles;
    @(negedge clk);
    adrE       = adr;
    ctrlM      = '0;
    writeDataM = wdata;
    ackDelay   = 3'($urandom % 5);
    @(negedge clk);
    ctrlM = ctrl;
    // Flags are combinational on the memory-stage inputs
    #1;
    snapSquash     = squashSc;
    snapLoadFault  = loadMisalignedFault;
    snapStoreFault = storeMisalignedFault;
    snapStall      = lsuStall;
    snapReq        = busReq.read | busReq.write;
    cycles         = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) begin
        reportFail($sformatf("Timeout in %s: lsuStall never fell", testName));
      end
    end while (lsuStall);
    lastRead      = readDataM;
    snapEndSquash = squashSc;
    // A CPU stall on top parks the access in DONE
    if (holdCycles > 0) begin
      stallM = 1'b1;
      repeat (holdCycles) begin
        @(negedge clk);
        checkWord("data held under stall", lastRead, readDataM);
        checkBit("no request under stall", 1'b0, busReq.read | busReq.write);
        checkBit("committed under stall", 1'b1, committedM);
      end
      stallM = 1'b0;
    end
    // The next instruction in memory is a bubble
    ctrlM = '0;
  endtask

  task automatic storeWord(input paddrT adr, input wordT data);
    runAccess(makeCtrl(2'b01, 3'b010, '0, 2'b00), adr, data, 0);
  endtask

  task automatic loadAndCheck(input paddrT adr, input funct3T f3, input wordT word);
    runAccess(makeCtrl(2'b10, f3, '0, 2'b00), adr, $urandom, 0);
    checkWord($sformatf("load f3 %b at %h", f3, adr), expectLoad(word, adr[1:0], f3),
              lastRead);
  endtask

  task automatic misalignedCase(input memRwT rw, input funct3T f3, input paddrT adr);
    runAccess(makeCtrl(rw, f3, '0, 2'b00), adr, $urandom, 0);
    checkBit("load fault", rw == 2'b10, snapLoadFault);
    checkBit("store fault", rw != 2'b10, snapStoreFault);
    checkBit("stall on fault", 1'b0, snapStall);
    checkBit("bus request on fault", 1'b0, snapReq);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic testLoads();
    paddrT adr;
    wordT  word;
    testName = "testLoads";
    for (int w = 0; w < 4; w++) begin
      adr  = 32'h40 + 32'(4 * w);
      word = $urandom;
      storeWord(adr, word);
      checkRw("stored word", adr, word);
      for (int off = 0; off < 4; off++) begin
        loadAndCheck(adr + 32'(off), 3'b000, word);
        loadAndCheck(adr + 32'(off), 3'b100, word);
        if (off % 2 == 0) begin
          loadAndCheck(adr + 32'(off), 3'b001, word);
          loadAndCheck(adr + 32'(off), 3'b101, word);
        end
      end
      loadAndCheck(adr, 3'b010, word);
    end
  endtask

  task automatic testStores();
    paddrT base;
    wordT  oldWord;
    wordT  data;
    wordT  expected;
    int    off;
    testName = "testStores";
    for (int w = 0; w < 4; w++) begin
      base    = 32'h80 + 32'(8 * w);
      oldWord = $urandom;
      storeWord(base, oldWord);
      expected = oldWord;
      // Register bits above the stored lane are random and must not reach memory
      off  = $urandom % 4;
      data = $urandom;
      runAccess(makeCtrl(2'b01, 3'b000, '0, 2'b00), base + 32'(off), data, 0);
      expected[8 * off +: 8] = data[7:0];
      off  = 2 * ($urandom % 2);
      data = $urandom;
      runAccess(makeCtrl(2'b01, 3'b001, '0, 2'b00), base + 32'(off), data, 0);
      expected[8 * off +: 16] = data[15:0];
      checkRw("merged lanes", base, expected);
      loadAndCheck(base, 3'b010, expected);
    end
  endtask

  task automatic testMisaligned();
    paddrT base;
    wordT  oldWord;
    memRwT rw;
    testName = "testMisaligned";
    base     = 32'hC0;
    oldWord  = $urandom;
    storeWord(base, oldWord);
    // Odd halfwords and any unaligned word, first as loads and then as stores
    for (int k = 0; k < 2; k++) begin
      rw = (k == 0) ? 2'b10 : 2'b01;
      for (int off = 1; off < 4; off++) begin
        if (off % 2 == 1) begin
          misalignedCase(rw, 3'b001, base + 32'(off));
        end
        misalignedCase(rw, 3'b010, base + 32'(off));
      end
    end
    checkRw("memory after faults", base, oldWord);
  endtask

  task automatic testLrSc();
    paddrT   adr;
    wordT    first;
    wordT    second;
    cpuCtrlT lr;
    cpuCtrlT sc;
    testName = "testLrSc";
    adr      = 32'hE0;
    lr       = makeCtrl(2'b10, 3'b010, '0, 2'b10);
    sc       = makeCtrl(2'b01, 3'b010, '0, 2'b10);
    first    = $urandom;
    second   = $urandom;
    storeWord(adr, first);
    storeWord(adr + 32'd4, second);
    runAccess(lr, adr, '0, 0);
    checkWord("LR data", first, lastRead);
    runAccess(sc, adr, ~first, 0);
    checkBit("SC squash after LR", 1'b0, snapSquash);
    checkBit("SC squash at completion", 1'b0, snapEndSquash);
    checkRw("SC write", adr, ~first);
    // The successful SC used up the reservation
    runAccess(sc, adr, first, 0);
    checkBit("SC squash without LR", 1'b1, snapSquash);
    checkBit("SC stall without LR", 1'b0, snapStall);
    checkRw("memory after failed SC", adr, ~first);
    // A reservation covers one word only
    runAccess(lr, adr, '0, 0);
    runAccess(sc, adr + 32'd4, first, 0);
    checkBit("SC squash on other word", 1'b1, snapSquash);
    checkRw("other word after failed SC", adr + 32'd4, second);
  endtask

  task automatic testAmo();
    amoOpT ops [0:8];
    paddrT adr;
    wordT  oldWord;
    wordT  operand;
    testName = "testAmo";
    ops = '{`AMO_SWAP, `AMO_ADD, `AMO_XOR, `AMO_AND, `AMO_OR,
            `AMO_MIN, `AMO_MAX, `AMO_MINU, `AMO_MAXU};
    for (int i = 0; i < 9; i++) begin
      adr     = 32'h10 + 32'(4 * i);
      oldWord = $urandom;
      operand = $urandom;
      storeWord(adr, oldWord);
      runAccess(makeCtrl(2'b11, 3'b010, ops[i], 2'b01), adr, operand, 0);
      checkWord($sformatf("AMO %b old value", ops[i]), oldWord, lastRead);
      checkRw($sformatf("AMO %b result", ops[i]), adr, expectAmo(ops[i], oldWord, operand));
    end
  endtask

  task automatic testStallHold();
    paddrT adr;
    wordT  word;
    int    acksBefore;
    testName = "testStallHold";
    adr      = 32'hF0;
    word     = $urandom;
    storeWord(adr, word);
    acksBefore = ackCount;
    runAccess(makeCtrl(2'b10, 3'b010, '0, 2'b00), adr, '0, 5);
    checkWord("held load data", word, lastRead);
    checkBit("single bus phase", 1'b1, ackCount == acksBefore + 1);
    // A trapped instruction stays off the bus
    acksBefore = ackCount;
    trapM      = 1'b1;
    runAccess(makeCtrl(2'b10, 3'b010, '0, 2'b00), adr, '0, 0);
    trapM = 1'b0;
    checkBit("stall on trap", 1'b0, snapStall);
    checkBit("bus request on trap", 1'b0, snapReq);
    checkBit("bus phases on trap", 1'b1, ackCount == acksBefore);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  // Bound assertions count their own failures, and the first one ends the run
  always @(negedge clk) begin
    if (u_dut.u_props.failCount != 0) begin
      reportFail("A bus or stall assertion failed during the run");
    end
  end

  initial begin
    void'($urandom(17681));
    rst        = 1'b1;
    stallM     = 1'b0;
    flushM     = 1'b0;
    trapM      = 1'b0;
    adrE       = '0;
    ctrlM      = '0;
    writeDataM = '0;
    ackDelay   = '0;
    testName   = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    checkBit("stall after reset", 1'b0, lsuStall);
    checkBit("committed after reset", 1'b0, committedM);
    testLoads();
    testStores();
    testMisaligned();
    testLrSc();
    testAmo();
    testStallHold();
    @(negedge clk);
    if (u_dut.u_props.failCount != 0) begin
      reportFail("A bus or stall assertion failed during the run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/subwordDp.sv
verilog/amoUnit.sv
verilog/busFsm.sv
verilog/lsu.sv
dv/lsu_props.sv
dv/lsu_tb.sv
